//--- Makefile
# Verilator simulation of the PBS control block
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_pbs_ctrl \
		-Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
+incdir+source
source/pbs_ctrl_pkg.sv
source/axil_decode.sv
source/ctrl_regfile.sv
source/pbs_launch.sv
source/pbs_ctrl_top.sv
tests/pbs_ctrl_props.sv
tests/pbs_ctrl_tb.sv

//--- source/axil_decode.sv
`timescale 1ns/1ps
`include "pbs_ctrl_macros.svh"

module axil_decode (
  input  logic                          S_AXI_ACLK,
  input  logic                          S_AXI_ARESETN,
  // write address
  input  logic [`AXI_ADDR_W-1:0]        S_AXI_AWADDR,
  input  logic [2:0]                    S_AXI_AWPROT,
  input  logic                          S_AXI_AWVALID,
  output logic                          S_AXI_AWREADY,
  // write data
  input  logic [`AXI_DATA_W-1:0]        S_AXI_WDATA,
  input  logic [`AXI_STRB_W-1:0]        S_AXI_WSTRB,
  input  logic                          S_AXI_WVALID,
  output logic                          S_AXI_WREADY,
  // write response
  output logic [1:0]                    S_AXI_BRESP,
  output logic                          S_AXI_BVALID,
  input  logic                          S_AXI_BREADY,
  // read address
  input  logic [`AXI_ADDR_W-1:0]        S_AXI_ARADDR,
  input  logic [2:0]                    S_AXI_ARPROT,
  input  logic                          S_AXI_ARVALID,
  output logic                          S_AXI_ARREADY,
  // read data
  output logic [`AXI_DATA_W-1:0]        S_AXI_RDATA,
  output logic [1:0]                    S_AXI_RRESP,
  output logic                          S_AXI_RVALID,
  input  logic                          S_AXI_RREADY,
  // register file side
  output pbs_ctrl_pkg::reg_wr_t         wr_req,
  output logic [`REG_IDX_W-1:0]         rd_index,
  input  logic [`AXI_DATA_W-1:0]        rd_word
);

  logic                   aw_ready_q;
  logic                   b_valid_q;
  logic                   ar_ready_q;
  logic                   r_valid_q;
  logic [`AXI_DATA_W-1:0] r_data_q;
  logic                   wr_accept;
  logic                   rd_accept;
  logic                   wr_in_range;
  logic                   rd_in_range;

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  // word index 4 and up has a nonzero upper field
  // prot bits carry no meaning for this block
  assign wr_in_range = (S_AXI_AWADDR[`AXI_ADDR_W-1:`ADDR_LSB+`REG_IDX_W] == '0);
  assign rd_in_range = (S_AXI_ARADDR[`AXI_ADDR_W-1:`ADDR_LSB+`REG_IDX_W] == '0);

  // ----------------------------------------------------------------------
  // write channel
  // ----------------------------------------------------------------------
  // address and data taken in the same cycle
  assign wr_accept = aw_ready_q && S_AXI_AWVALID && S_AXI_WVALID;

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN)
  begin
    if (!S_AXI_ARESETN)
    begin
      aw_ready_q <= 1'b0;
      b_valid_q  <= 1'b0;
    end
    else
    begin
      // one-cycle accept pulse, held off while a response is pending
      aw_ready_q <= !aw_ready_q && S_AXI_AWVALID && S_AXI_WVALID && !b_valid_q;
      if (wr_accept)
        b_valid_q <= 1'b1;
      else if (S_AXI_BREADY)
        b_valid_q <= 1'b0;
    end
  end

  // request goes out on the accept cycle
  always_comb
  begin
    wr_req.en   = wr_accept && wr_in_range;
    wr_req.idx  = S_AXI_AWADDR[`ADDR_LSB +: `REG_IDX_W];
    wr_req.data = S_AXI_WDATA;
    wr_req.strb = S_AXI_WSTRB;
  end

  assign S_AXI_AWREADY = aw_ready_q;
  assign S_AXI_WREADY  = aw_ready_q;
  assign S_AXI_BVALID  = b_valid_q;
  assign S_AXI_BRESP   = `RESP_OKAY;

  // ----------------------------------------------------------------------
  // read channel
  // ----------------------------------------------------------------------
  assign rd_accept = ar_ready_q && S_AXI_ARVALID;
  assign rd_index  = S_AXI_ARADDR[`ADDR_LSB +: `REG_IDX_W];

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN)
  begin
    if (!S_AXI_ARESETN)
    begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
    end
    else if (rd_accept)
    begin
      r_valid_q  <= 1'b1;
      ar_ready_q <= 1'b0;
    end
    else if (r_valid_q && S_AXI_RREADY)
    begin
      r_valid_q  <= 1'b0;
      ar_ready_q <= 1'b1;
    end
    else if (!r_valid_q)
      // first cycle out of reset
      ar_ready_q <= 1'b1;
  end

  // read word captured at the address handshake
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN)
  begin
    if (!S_AXI_ARESETN)
      r_data_q <= '0;
    else if (rd_accept)
      r_data_q <= rd_in_range ? rd_word : '0;
  end

  assign S_AXI_ARREADY = ar_ready_q;
  assign S_AXI_RVALID  = r_valid_q;
  assign S_AXI_RDATA   = r_data_q;
  assign S_AXI_RRESP   = `RESP_OKAY;

endmodule

//--- source/ctrl_regfile.sv
`timescale 1ns/1ps
`include "pbs_ctrl_macros.svh"

module ctrl_regfile (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  pbs_ctrl_pkg::reg_wr_t   wr_req,
  input  logic [`REG_IDX_W-1:0]   rd_index,
  output logic [`AXI_DATA_W-1:0]  rd_word,
  input  logic                    pbs_busy,
  input  logic                    pbs_done,
  output pbs_ctrl_pkg::ctrl_word_u ctrl
);

  // register 0 is control and status
  pbs_ctrl_pkg::ctrl_word_u ctrl_q;
  // registers 1 to 3, host scratch
  logic [`AXI_DATA_W-1:0]   scratch_q [1:`REG_COUNT-1];

  // byte lanes with strobe set take new data
  function automatic logic [`AXI_DATA_W-1:0] merge_bytes(
    input logic [`AXI_DATA_W-1:0] old_word,
    input logic [`AXI_DATA_W-1:0] new_word,
    input logic [`AXI_STRB_W-1:0] strb
  );
    logic [`AXI_DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < `AXI_STRB_W; b++)
    begin
      if (strb[b])
        res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  // ----------------------------------------------------------------------
  // host writes, then status merge on top
  // ----------------------------------------------------------------------
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN)
  begin
    if (!S_AXI_ARESETN)
    begin
      ctrl_q <= '0;
      for (int r = 1; r < `REG_COUNT; r++)
        scratch_q[r] <= '0;
    end
    else
    begin
      if (wr_req.en)
      begin
        if (wr_req.idx == '0)
          ctrl_q.raw <= merge_bytes(ctrl_q.raw, wr_req.data, wr_req.strb);
        else
          scratch_q[wr_req.idx] <= merge_bytes(scratch_q[wr_req.idx], wr_req.data,
                                               wr_req.strb);
      end
      // later assignments win over the host write
      ctrl_q.f.busy <= pbs_busy;
      if (pbs_done)
      begin
        ctrl_q.f.start <= 1'b0;
        ctrl_q.f.done  <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------
  always_comb
  begin
    if (rd_index == '0)
      rd_word = ctrl_q.raw;
    else
      rd_word = scratch_q[rd_index];
  end

  assign ctrl = ctrl_q;

endmodule

//--- source/pbs_ctrl_macros.svh
`ifndef PBS_CTRL_MACROS_SVH
`define PBS_CTRL_MACROS_SVH

// ----------------------------------------------------------------------
// bus geometry
// ----------------------------------------------------------------------
`define AXI_DATA_W 32
`define AXI_ADDR_W 6
// one strobe per byte lane
`define AXI_STRB_W (`AXI_DATA_W / 8)

// ----------------------------------------------------------------------
// register map
// ----------------------------------------------------------------------
`define REG_COUNT 4
`define REG_IDX_W 2
// byte offset bits below the word index
`define ADDR_LSB 2
`define RESP_OKAY 2'b00

`endif

//--- source/pbs_ctrl_pkg.sv
`include "pbs_ctrl_macros.svh"

package pbs_ctrl_pkg;

  // ----------------------------------------------------------------------
  // host write request, decode to execute
  // ----------------------------------------------------------------------
  typedef struct packed {
    // low when the word index is out of range
    logic                   en;
    logic [`REG_IDX_W-1:0]  idx;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } reg_wr_t;

  // ----------------------------------------------------------------------
  // register 0 layout
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [23:0] rsvd_hi;
    // stack 1 rd/wr, stack 0 rd/wr
    logic [3:0]  hbm_sel;
    logic        rsvd_3;
    // sticky until host clears it
    logic        done;
    // mirror of processor busy
    logic        busy;
    logic        start;
  } ctrl_fields_t;

  // raw bus word or named fields
  typedef union packed {
    logic [`AXI_DATA_W-1:0] raw;
    ctrl_fields_t           f;
  } ctrl_word_u;

endpackage

//--- source/pbs_ctrl_top.sv
`timescale 1ns/1ps
`include "pbs_ctrl_macros.svh"

module pbs_ctrl_top (
  input  logic                   S_AXI_ACLK,
  input  logic                   S_AXI_ARESETN,
  input  logic [`AXI_ADDR_W-1:0] S_AXI_AWADDR,
  input  logic [2:0]             S_AXI_AWPROT,
  input  logic                   S_AXI_AWVALID,
  output logic                   S_AXI_AWREADY,
  input  logic [`AXI_DATA_W-1:0] S_AXI_WDATA,
  input  logic [`AXI_STRB_W-1:0] S_AXI_WSTRB,
  input  logic                   S_AXI_WVALID,
  output logic                   S_AXI_WREADY,
  output logic [1:0]             S_AXI_BRESP,
  output logic                   S_AXI_BVALID,
  input  logic                   S_AXI_BREADY,
  input  logic [`AXI_ADDR_W-1:0] S_AXI_ARADDR,
  input  logic [2:0]             S_AXI_ARPROT,
  input  logic                   S_AXI_ARVALID,
  output logic                   S_AXI_ARREADY,
  output logic [`AXI_DATA_W-1:0] S_AXI_RDATA,
  output logic [1:0]             S_AXI_RRESP,
  output logic                   S_AXI_RVALID,
  input  logic                   S_AXI_RREADY,
  // processor side
  input  logic                   pbs_busy,
  input  logic                   pbs_done,
  output logic                   start_pbs,
  output logic                   tfhe_reset_n,
  output logic [3:0]             hbm_rw_select
);

  pbs_ctrl_pkg::reg_wr_t    wr_req;
  logic [`REG_IDX_W-1:0]    rd_index;
  logic [`AXI_DATA_W-1:0]   rd_word;
  pbs_ctrl_pkg::ctrl_word_u ctrl;

  // ----------------------------------------------------------------------
  // decode, execute, result
  // ----------------------------------------------------------------------
  axil_decode u_decode (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .S_AXI_AWADDR, .S_AXI_AWPROT, .S_AXI_AWVALID, .S_AXI_AWREADY,
    .S_AXI_WDATA, .S_AXI_WSTRB, .S_AXI_WVALID, .S_AXI_WREADY,
    .S_AXI_BRESP, .S_AXI_BVALID, .S_AXI_BREADY,
    .S_AXI_ARADDR, .S_AXI_ARPROT, .S_AXI_ARVALID, .S_AXI_ARREADY,
    .S_AXI_RDATA, .S_AXI_RRESP, .S_AXI_RVALID, .S_AXI_RREADY,
    .wr_req, .rd_index, .rd_word
  );

  ctrl_regfile u_regfile (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .wr_req, .rd_index, .rd_word,
    .pbs_busy, .pbs_done,
    .ctrl
  );

  pbs_launch u_launch (
    .S_AXI_ACLK, .S_AXI_ARESETN,
    .ctrl,
    .start_pbs, .hbm_rw_select, .tfhe_reset_n
  );

endmodule

//--- source/pbs_launch.sv
`timescale 1ns/1ps

module pbs_launch (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  pbs_ctrl_pkg::ctrl_word_u ctrl,
  output logic                     start_pbs,
  output logic [3:0]               hbm_rw_select,
  output logic                     tfhe_reset_n
);

  logic start_d_q;
  logic reset_n_q;

  // straight field decode
  assign start_pbs     = ctrl.f.start;
  assign hbm_rw_select = ctrl.f.hbm_sel;

  // ----------------------------------------------------------------------
  // processor reset release
  // ----------------------------------------------------------------------
  // release on start rise, hold in reset once start drops
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN)
  begin
    if (!S_AXI_ARESETN)
    begin
      start_d_q <= 1'b0;
      reset_n_q <= 1'b0;
    end
    else
    begin
      start_d_q <= start_pbs;
      if (start_pbs && !start_d_q)
        reset_n_q <= 1'b1;
      else if (!start_pbs)
        reset_n_q <= 1'b0;
    end
  end

  assign tfhe_reset_n = reset_n_q;

endmodule

//--- tests/pbs_ctrl_props.sv
`timescale 1ns/1ps

module pbs_ctrl_props (
  input logic clk,
  input logic rst_n,
  input logic awready,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic start_pbs,
  input logic tfhe_reset_n
);

  // ----------------------------------------------------------------------
  // response channels hold until taken
  // ----------------------------------------------------------------------
  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("write response dropped before BREADY");

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else $error("read data dropped before RREADY");

  // no new write accepted with a response pending
  aw_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    !(awready && bvalid))
    else $error("AWREADY high while BVALID high");

  // ----------------------------------------------------------------------
  // processor reset trails the start bit by one cycle
  // ----------------------------------------------------------------------
  reset_release: assert property (@(posedge clk) disable iff (!rst_n)
    tfhe_reset_n == $past(start_pbs))
    else $error("tfhe_reset_n does not follow start_pbs");

endmodule

// top ports carry both the decode and the launch signals
bind pbs_ctrl_top pbs_ctrl_props u_props (
  .clk(S_AXI_ACLK), .rst_n(S_AXI_ARESETN),
  .awready(S_AXI_AWREADY), .bvalid(S_AXI_BVALID), .bready(S_AXI_BREADY),
  .rvalid(S_AXI_RVALID), .rready(S_AXI_RREADY),
  .start_pbs(start_pbs), .tfhe_reset_n(tfhe_reset_n)
);

//--- tests/pbs_ctrl_tb.sv
`timescale 1ns/1ps
`include "pbs_ctrl_macros.svh"

module tb_pbs_ctrl;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_RANDOM = 60;
  // random writes and reads plus the directed phases
  localparam int NUM_TXN    = 2 * NUM_RANDOM + 30;
  // worst case handshake waits and stalls per transaction
  localparam int TXN_CYCLES = 20;

  logic                   aclk;
  logic                   aresetn;
  logic [`AXI_ADDR_W-1:0] awaddr, araddr;
  logic [2:0]             awprot, arprot;
  logic                   awvalid, awready, wvalid, wready;
  logic [`AXI_DATA_W-1:0] wdata, rdata;
  logic [`AXI_STRB_W-1:0] wstrb;
  logic [1:0]             bresp, rresp;
  logic                   bvalid, bready, arvalid, arready, rvalid, rready;
  logic                   pbs_busy, pbs_done, start_pbs, tfhe_reset_n;
  logic [3:0]             hbm_rw_select;

  // host view of the four registers
  logic [31:0] model_regs [0:3];
  logic [31:0] exp_q [$];
  logic [31:0] got_q [$];
  logic        start_seen;
  event        read_seen;

  pbs_ctrl_top DUT (
    .S_AXI_ACLK(aclk), .S_AXI_ARESETN(aresetn),
    .S_AXI_AWADDR(awaddr), .S_AXI_AWPROT(awprot),
    .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
    .S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb),
    .S_AXI_WVALID(wvalid), .S_AXI_WREADY(wready),
    .S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid), .S_AXI_BREADY(bready),
    .S_AXI_ARADDR(araddr), .S_AXI_ARPROT(arprot),
    .S_AXI_ARVALID(arvalid), .S_AXI_ARREADY(arready),
    .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
    .S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
    .pbs_busy(pbs_busy), .pbs_done(pbs_done),
    .start_pbs(start_pbs), .tfhe_reset_n(tfhe_reset_n),
    .hbm_rw_select(hbm_rw_select)
  );

  initial
  begin
    aclk = 1'b0;
    forever
      #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  // register word after one edge: byte mask first, then status merge
  function automatic logic [31:0] next_reg_word(
    input logic [31:0] old_word,
    input logic [31:0] data,
    input logic [3:0]  strb,
    input logic        we,
    input logic        is_ctrl,
    input logic        busy,
    input logic        done
  );
    logic [31:0] w;
    w = old_word;
    for (int b = 0; b < 4; b++)
    begin
      if (we && strb[b])
        w[8*b +: 8] = data[8*b +: 8];
    end
    if (is_ctrl)
    begin
      // bit 1 busy, bit 0 start, bit 2 done
      w[1] = busy;
      if (done)
      begin
        w[0] = 1'b0;
        w[2] = 1'b1;
      end
    end
    return w;
  endfunction

  // word index 4 and up reads zero
  function automatic logic [31:0] expected_read(input logic [`AXI_ADDR_W-1:0] addr);
    int widx;
    widx = int'(addr[`AXI_ADDR_W-1:2]);
    if (widx >= 4)
      return 32'h0;
    return model_regs[widx];
  endfunction

  // one edge with no host write, only status
  task automatic step_status_model();
    model_regs[0] = next_reg_word(model_regs[0], 32'h0, 4'h0, 1'b0, 1'b1, pbs_busy, pbs_done);
  endtask

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "check failed: %s", what);
    end
  endtask

  // read data against the model
  initial
  begin
    forever
    begin
      @(read_seen);
      while (got_q.size() != 0)
        check_value(got_q.pop_front(), exp_q.pop_front(), "read data");
    end
  end

  // tfhe_reset_n against the modelled start bit of the cycle before, sampled mid-cycle
  initial
  begin
    start_seen = 1'b0;
    forever
    begin
      @(posedge aclk);
      #2;
      if (aresetn)
        check_value(32'(tfhe_reset_n), 32'(start_seen), "tfhe_reset_n release");
      start_seen = model_regs[0][0];
    end
  end

  initial
  begin
    #(NUM_TXN * TXN_CYCLES * CLK_PERIOD);
    $display("timeout: bus transactions did not finish in time");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  // ----------------------------------------------------------------------
  // bus tasks
  // ----------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge aclk);
    #1;
  endtask

  task automatic bus_write(
    input logic [`AXI_ADDR_W-1:0] addr,
    input logic [31:0]            data,
    input logic [3:0]             strb
  );
    int widx;
    widx    = int'(addr[`AXI_ADDR_W-1:2]);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awprot  = 3'($urandom);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // ready seen here holds through the next edge
    while (!awready)
    begin
      check_value(32'(wready), 32'h0, "WREADY without AWREADY");
      next_cycle();
    end
    check_value(32'(wready), 32'h1, "WREADY with AWREADY");
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (int r = 0; r < 4; r++)
      model_regs[r] = next_reg_word(model_regs[r], data, strb, widx == r, r == 0,
                                    pbs_busy, pbs_done);
    // back-pressure on B
    repeat ($urandom_range(0, 4))
      next_cycle();
    bready = 1'b1;
    while (!bvalid)
      next_cycle();
    check_value(32'(bresp), 32'(`RESP_OKAY), "write response code");
    next_cycle();
    bready = 1'b0;
    check_value(32'(bvalid), 32'h0, "write response repeated");
  endtask

  task automatic bus_read(input logic [`AXI_ADDR_W-1:0] addr);
    araddr  = addr;
    arprot  = 3'($urandom);
    arvalid = 1'b1;
    while (!arready)
      next_cycle();
    exp_q.push_back(expected_read(addr));
    next_cycle();
    arvalid = 1'b0;
    repeat ($urandom_range(0, 4))
      next_cycle();
    rready = 1'b1;
    while (!rvalid)
      next_cycle();
    got_q.push_back(rdata);
    check_value(32'(rresp), 32'(`RESP_OKAY), "read response code");
    -> read_seen;
    next_cycle();
    rready = 1'b0;
    check_value(32'(rvalid), 32'h0, "read data repeated");
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    void'($urandom(32'h2fc88e12));
    aresetn = 1'b0;
    {awaddr, awprot, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {araddr, arprot, arvalid, rready, pbs_busy, pbs_done} = '0;
    for (int r = 0; r < 4; r++)
      model_regs[r] = 32'h0;
    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    // everything zero out of reset
    for (int r = 0; r < 4; r++)
      bus_read(6'(r * 4));
    check_value(32'(start_pbs), 32'h0, "start_pbs after reset");
    check_value(32'(tfhe_reset_n), 32'h0, "tfhe_reset_n after reset");

    // scratch and out-of-range words, random strobes and stalls
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      bus_write(6'($urandom_range(1, 15) * 4), $urandom, 4'($urandom));
      bus_read(6'($urandom_range(1, 15) * 4));
    end

    // start with hbm select 0xa
    bus_write(6'h00, 32'h0000_00a1, 4'b0001);
    check_value(32'(start_pbs), 32'h1, "start_pbs after start write");
    check_value(32'(hbm_rw_select), 32'ha, "hbm_rw_select");
    check_value(32'(tfhe_reset_n), 32'h1, "tfhe_reset_n after start");
    bus_read(6'h00);

    // busy mirrored, host cannot move bit 1
    pbs_busy = 1'b1;
    next_cycle();
    step_status_model();
    bus_read(6'h00);
    bus_write(6'h00, 32'h0000_00a1, 4'b0001);
    bus_read(6'h00);
    pbs_busy = 1'b0;
    next_cycle();
    step_status_model();
    bus_write(6'h00, 32'h0000_00a3, 4'b0001);
    bus_read(6'h00);

    // done pulse ends the run
    pbs_done = 1'b1;
    next_cycle();
    step_status_model();
    pbs_done = 1'b0;
    check_value(32'(start_pbs), 32'h0, "start_pbs after done");
    check_value(32'(tfhe_reset_n), 32'h1, "tfhe_reset_n on done edge");
    next_cycle();
    check_value(32'(tfhe_reset_n), 32'h0, "tfhe_reset_n after done");
    bus_read(6'h00);
    // host clears done with done low
    bus_write(6'h00, 32'h0000_0000, 4'b0001);
    bus_read(6'h00);

    $display(">>> PASS");
    $finish;
  end

endmodule
